// File: sources.f
rtl/dcache_pkg.sv
rtl/dcache_ctrl.sv
rtl/dcache_tag_array.sv
rtl/dcache_data_array.sv
rtl/amo_unit.sv
rtl/dcache_top.sv
test/dcache_checker.sv
test/tb_dcache.sv

// File: test/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

  localparam int CLK_PERIOD = 8;
  localparam int N_OPS      = 400;
  localparam int TIMEOUT_NS = N_OPS * 20 * CLK_PERIOD;  // 20 cycles per operation
  localparam logic [dcache_pkg::ADDR_W-1:0] WINDOW_BASE = 10'h140;

  logic                          clk, rst;
  logic                          cpu_rden, cpu_wren, cpu_amoen;
  logic [dcache_pkg::ADDR_W-1:0] cpu_addr, mem_addr;
  logic [dcache_pkg::DATA_W-1:0] cpu_wdata, cpu_rdata;
  dcache_pkg::amo_op_e           cpu_amo_op;
  logic                          glob_stall, dcache_stall;
  logic                          mem_rden, mem_wren, mem_ready;
  logic [dcache_pkg::DATA_W-1:0] mem_rdata, mem_wdata;
  int                            errors;

  logic [dcache_pkg::DATA_W-1:0] main_mem [1 << dcache_pkg::ADDR_W];
  logic                          mem_busy;
  int                            mem_wait;
  integer                        seed;
  integer                        delay_seed;
  logic [dcache_pkg::ADDR_W-1:0] last_addr;
  dcache_pkg::amo_op_e           amo_ops [6];

  dcache_top dcache_top_i (.*);

  dcache_checker checker_i (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, the run hung", TIMEOUT_NS);
    $display("Some tests failed");
    $finish;
  end

  // Main memory, one ready pulse 1 to 4 cycles after an enable
  always @(posedge clk) begin
    if (rst) begin
      mem_ready <= 1'b0;
      mem_busy  <= 1'b0;
    end else if (mem_ready) begin
      mem_ready <= 1'b0;
    end else if (mem_busy) begin
      if (mem_wait == 0) begin
        mem_ready <= 1'b1;
        mem_busy  <= 1'b0;
        if (mem_wren) begin
          main_mem[mem_addr] <= mem_wdata;
        end else begin
          mem_rdata <= main_mem[mem_addr];
        end
      end else begin
        mem_wait <= mem_wait - 1;
      end
    end else if (mem_rden || mem_wren) begin
      mem_busy <= 1'b1;
      mem_wait <= {$random(delay_seed)} % 4;
    end
  end

  task automatic drive_random_op();
    logic [31:0] r;
    r = $random(seed);
    if (r[6:5] != 2'b00) begin
      last_addr = WINDOW_BASE + r[12:7];   // 64-word window, frequent conflicts
    end
    cpu_addr   <= last_addr;
    cpu_wdata  <= $random(seed);
    cpu_amo_op <= amo_ops[{$random(seed)} % 6];
    cpu_rden   <= (r[3:0] < 4'd7);
    cpu_wren   <= (r[3:0] >= 4'd7) && (r[3:0] < 4'd13);
    cpu_amoen  <= (r[3:0] >= 4'd13);
  endtask

  initial begin
    logic [31:0] r;
    int i;
    seed       = 32'hc88f;
    delay_seed = seed + 1;
    rst        = 1'b1;
    cpu_rden   = 1'b0;
    cpu_wren   = 1'b0;
    cpu_amoen  = 1'b0;
    cpu_addr   = '0;
    cpu_wdata  = '0;
    cpu_amo_op = dcache_pkg::AMO_SWAP;
    glob_stall = 1'b0;
    mem_ready  = 1'b0;
    mem_rdata  = '0;
    last_addr  = WINDOW_BASE;
    amo_ops    = '{dcache_pkg::AMO_SWAP, dcache_pkg::AMO_ADD, dcache_pkg::AMO_AND,
                   dcache_pkg::AMO_OR, dcache_pkg::AMO_XOR, dcache_pkg::AMO_MAX};
    for (i = 0; i < (1 << dcache_pkg::ADDR_W); i++) begin
      main_mem[i] = {6'h2b, i[9:0], ~i[9:0], i[5:0]};  // Address pattern
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (i = 0; i < N_OPS; i++) begin
      r = $random(seed);
      if (r[3:2] == 2'b00) begin
        cpu_rden  <= 1'b0;
        cpu_wren  <= 1'b0;
        cpu_amoen <= 1'b0;
        repeat (r[5:4] + 1) @(posedge clk);
      end
      drive_random_op();
      @(posedge clk);
      while (dcache_stall) @(posedge clk);  // Accepted at this edge
    end
    cpu_rden  <= 1'b0;
    cpu_wren  <= 1'b0;
    cpu_amoen <= 1'b0;
    @(posedge clk);
    while (dcache_stall) @(posedge clk);    // Last access completes
    repeat (2) @(posedge clk);
    checker_i.print_summary();
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: test/dcache_checker.sv
`timescale 1ns/1ps

module dcache_checker (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          cpu_rden,
  input  logic                          cpu_wren,
  input  logic                          cpu_amoen,
  input  logic [dcache_pkg::ADDR_W-1:0] cpu_addr,
  input  logic [dcache_pkg::DATA_W-1:0] cpu_wdata,
  input  dcache_pkg::amo_op_e           cpu_amo_op,
  input  logic                          glob_stall,
  input  logic [dcache_pkg::DATA_W-1:0] cpu_rdata,
  input  logic                          dcache_stall,
  input  logic                          mem_rden,
  input  logic                          mem_wren,
  input  logic [dcache_pkg::ADDR_W-1:0] mem_addr,
  input  logic [dcache_pkg::DATA_W-1:0] mem_wdata,
  output int                            errors
);

  localparam int READS       = 0;
  localparam int WRITES      = 1;
  localparam int WRITE_BACK  = 2;
  localparam int AMO         = 3;
  localparam int HIT_LATENCY = 4;
  localparam int RESET       = 5;

  string                         names [6];
  int                            checks [6];
  int                            fails [6];
  logic [dcache_pkg::DATA_W-1:0] ref_mem [1 << dcache_pkg::ADDR_W];
  logic [1:0]                    last_src [1 << dcache_pkg::ADDR_W];  // 1 write, 2 AMO
  logic [dcache_pkg::TAG_W-1:0]  line_tag [dcache_pkg::LINES];
  logic [dcache_pkg::LINES-1:0]  line_valid;
  logic                          pending, pend_rd, pend_wr, pend_hit;
  logic                          first_access, saw_rden, reset_seen;
  logic [dcache_pkg::ADDR_W-1:0] pend_addr;
  logic [dcache_pkg::DATA_W-1:0] pend_wdata;
  dcache_pkg::amo_op_e           pend_op;
  int                            latency;

  initial begin
    int i;
    names  = '{"reads", "writes", "write_back", "amo", "hit_latency", "reset"};
    checks = '{default: 0};
    fails  = '{default: 0};
    errors = 0;
    for (i = 0; i < (1 << dcache_pkg::ADDR_W); i++) begin
      ref_mem[i]  = {6'h2b, i[9:0], ~i[9:0], i[5:0]};
      last_src[i] = 2'd0;
    end
  end

  function automatic logic [31:0] amo_expect(dcache_pkg::amo_op_e op, logic [31:0] old,
                                             logic [31:0] operand);
    case (op)
      dcache_pkg::AMO_ADD: return old + operand;
      dcache_pkg::AMO_AND: return old & operand;
      dcache_pkg::AMO_OR:  return old | operand;
      dcache_pkg::AMO_XOR: return old ^ operand;
      dcache_pkg::AMO_MAX: return ($signed(old) < $signed(operand)) ? operand : old;
      default:             return operand;  // Swap
    endcase
  endfunction

  task automatic check_value(input int test, input logic [9:0] addr,
                             input logic [31:0] expected, input logic [31:0] actual);
    checks[test]++;
    if (expected !== actual) begin
      fails[test]++;
      errors++;
      $display("FAIL %s addr 0x%03h: expected 0x%08h, actual 0x%08h",
               names[test], addr, expected, actual);
    end
  endtask

  task automatic complete_access();
    logic [9:0] a;
    a = pend_addr;
    if (pend_hit) begin
      check_value(HIT_LATENCY, a, pend_rd || pend_wr ? 1 : 3, latency);
    end
    if (pend_rd) begin
      check_value(READS, a, ref_mem[a], cpu_rdata);
      if (last_src[a] != 2'd0) begin
        check_value(last_src[a] == 2'd1 ? WRITES : AMO, a, ref_mem[a], cpu_rdata);
      end
    end else if (pend_wr) begin
      ref_mem[a]  = pend_wdata;
      last_src[a] = 2'd1;
    end else begin
      check_value(AMO, a, ref_mem[a], cpu_rdata);  // Old value back to the CPU
      ref_mem[a]  = amo_expect(pend_op, ref_mem[a], pend_wdata);
      last_src[a] = 2'd2;
    end
    if (first_access) begin
      checks[RESET]++;
      if (!saw_rden) begin
        fails[RESET]++;
        errors++;
        $display("reset: the first access after reset did not issue a memory read");
      end
      first_access = 1'b0;
    end
    line_tag[a[3:0]]   = a[9:4];    // Every access leaves its word in the line
    line_valid[a[3:0]] = 1'b1;
    pending            = 1'b0;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      pending      = 1'b0;
      line_valid   = '0;
      first_access = 1'b1;
      reset_seen   = 1'b0;
    end else begin
      if (!reset_seen) begin
        check_value(RESET, '0, 32'd0, {29'd0, dcache_stall, mem_rden, mem_wren});
        reset_seen = 1'b1;
      end
      if (mem_wren) begin
        check_value(WRITE_BACK, mem_addr, ref_mem[mem_addr], mem_wdata);
      end
      if (pending) begin
        latency++;
        saw_rden = saw_rden || mem_rden;
        if (!dcache_stall) begin
          complete_access();
        end
      end
      if (!dcache_stall && !glob_stall && (cpu_rden || cpu_wren || cpu_amoen)) begin
        pending    = 1'b1;
        pend_rd    = cpu_rden;
        pend_wr    = cpu_wren;
        pend_addr  = cpu_addr;
        pend_wdata = cpu_wdata;
        pend_op    = cpu_amo_op;
        pend_hit   = line_valid[cpu_addr[3:0]] && (line_tag[cpu_addr[3:0]] == cpu_addr[9:4]);
        latency    = 0;
        saw_rden   = 1'b0;
      end
    end
  end

  task automatic print_summary();
    int t;
    int total_checks;
    total_checks = 0;
    for (t = 0; t < 6; t++) begin
      $display("%s: %0d checks, %0d failed", names[t], checks[t], fails[t]);
      total_checks += checks[t];
    end
    $display("Total: %0d checks, %0d failed", total_checks, errors);
  endtask

endmodule

// File: rtl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          cpu_rden,
  input  logic                          cpu_wren,
  input  logic                          cpu_amoen,
  input  logic [dcache_pkg::ADDR_W-1:0] cpu_addr,
  input  logic [dcache_pkg::DATA_W-1:0] cpu_wdata,
  input  dcache_pkg::amo_op_e           cpu_amo_op,
  input  logic                          glob_stall,
  input  logic [dcache_pkg::DATA_W-1:0] mem_rdata,
  input  logic                          mem_ready,
  output logic [dcache_pkg::DATA_W-1:0] cpu_rdata,
  output logic                          dcache_stall,
  output logic                          mem_rden,
  output logic                          mem_wren,
  output logic [dcache_pkg::ADDR_W-1:0] mem_addr,
  output logic [dcache_pkg::DATA_W-1:0] mem_wdata
);

  logic [dcache_pkg::ADDR_W-1:0] req_addr;
  logic [dcache_pkg::DATA_W-1:0] req_wdata;
  dcache_pkg::amo_op_e           req_op;
  dcache_pkg::insel_e            cache_insel;
  logic                          cache_wren;
  logic                          set_dirty, set_valid, replace_tag, tag_sel;
  logic                          hit, dirty;
  logic                          amo_buffer_en, amo_unit_en;
  logic [dcache_pkg::DATA_W-1:0] line_rdata;
  logic [dcache_pkg::DATA_W-1:0] amo_result;

  dcache_ctrl ctrl_i (
    .clk(clk), .rst(rst),
    .cpu_rden(cpu_rden), .cpu_wren(cpu_wren), .cpu_amoen(cpu_amoen),
    .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .cpu_amo_op(cpu_amo_op),
    .glob_stall(glob_stall), .hit(hit), .dirty(dirty), .mem_ready(mem_ready),
    .req_addr(req_addr), .req_wdata(req_wdata), .req_op(req_op),
    .cache_wren(cache_wren), .cache_insel(cache_insel),
    .mem_rden(mem_rden), .mem_wren(mem_wren),
    .set_dirty(set_dirty), .set_valid(set_valid), .replace_tag(replace_tag),
    .tag_sel(tag_sel), .amo_buffer_en(amo_buffer_en), .amo_unit_en(amo_unit_en),
    .dcache_stall(dcache_stall)
  );

  dcache_tag_array tag_array_i (
    .clk(clk), .rst(rst), .req_addr(req_addr),
    .set_valid(set_valid), .set_dirty(set_dirty), .replace_tag(replace_tag),
    .tag_sel(tag_sel), .hit(hit), .dirty(dirty), .mem_addr(mem_addr)
  );

  dcache_data_array data_array_i (
    .clk(clk), .req_addr(req_addr), .req_wdata(req_wdata),
    .mem_rdata(mem_rdata), .amo_result(amo_result),
    .cache_wren(cache_wren), .cache_insel(cache_insel),
    .line_rdata(line_rdata), .mem_wdata(mem_wdata)
  );

  amo_unit amo_unit_i (
    .clk(clk), .rst(rst), .line_rdata(line_rdata), .req_wdata(req_wdata),
    .req_op(req_op), .amo_buffer_en(amo_buffer_en), .amo_unit_en(amo_unit_en),
    .amo_result(amo_result), .cpu_rdata(cpu_rdata)
  );

endmodule

// File: rtl/amo_unit.sv
`timescale 1ns/1ps

module amo_unit (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [dcache_pkg::DATA_W-1:0] line_rdata,
  input  logic [dcache_pkg::DATA_W-1:0] req_wdata,
  input  dcache_pkg::amo_op_e           req_op,
  input  logic                          amo_buffer_en,
  input  logic                          amo_unit_en,
  output logic [dcache_pkg::DATA_W-1:0] amo_result,
  output logic [dcache_pkg::DATA_W-1:0] cpu_rdata
);

  logic [dcache_pkg::DATA_W-1:0] old_value;

  // The buffer loads before the modify step and holds during it
  always_ff @(posedge clk) begin
    if (rst) begin
      old_value <= '0;
    end else if (amo_buffer_en && !amo_unit_en) begin
      old_value <= line_rdata;
    end
  end

  always_comb begin
    case (req_op)
      dcache_pkg::AMO_SWAP: amo_result = req_wdata;
      dcache_pkg::AMO_ADD:  amo_result = old_value + req_wdata;
      dcache_pkg::AMO_AND:  amo_result = old_value & req_wdata;
      dcache_pkg::AMO_OR:   amo_result = old_value | req_wdata;
      dcache_pkg::AMO_XOR:  amo_result = old_value ^ req_wdata;
      dcache_pkg::AMO_MAX: begin
        if ($signed(old_value) > $signed(req_wdata)) begin
          amo_result = old_value;
        end else begin
          amo_result = req_wdata;
        end
      end
      default:              amo_result = req_wdata;
    endcase
  end

  // AMOs return the value before the update
  assign cpu_rdata = amo_unit_en ? old_value : line_rdata;

endmodule

// File: rtl/dcache_data_array.sv
`timescale 1ns/1ps

module dcache_data_array (
  input  logic                          clk,
  input  logic [dcache_pkg::ADDR_W-1:0] req_addr,
  input  logic [dcache_pkg::DATA_W-1:0] req_wdata,
  input  logic [dcache_pkg::DATA_W-1:0] mem_rdata,
  input  logic [dcache_pkg::DATA_W-1:0] amo_result,
  input  logic                          cache_wren,
  input  dcache_pkg::insel_e            cache_insel,
  output logic [dcache_pkg::DATA_W-1:0] line_rdata,
  output logic [dcache_pkg::DATA_W-1:0] mem_wdata
);

  logic [dcache_pkg::DATA_W-1:0]  data_mem [dcache_pkg::LINES];
  logic [dcache_pkg::DATA_W-1:0]  wr_data;
  logic [dcache_pkg::INDEX_W-1:0] index;

  assign index = req_addr[dcache_pkg::INDEX_W-1:0];

  always_comb begin
    case (cache_insel)
      dcache_pkg::INSEL_MEM: wr_data = mem_rdata;   // Refill
      dcache_pkg::INSEL_AMO: wr_data = amo_result;
      default:               wr_data = req_wdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (cache_wren) begin
      data_mem[index] <= wr_data;
    end
  end

  assign line_rdata = data_mem[index];
  assign mem_wdata  = data_mem[index];  // Write-back of the victim word

endmodule

// File: rtl/dcache_tag_array.sv
`timescale 1ns/1ps

module dcache_tag_array (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [dcache_pkg::ADDR_W-1:0] req_addr,
  input  logic                          set_valid,
  input  logic                          set_dirty,
  input  logic                          replace_tag,
  input  logic                          tag_sel,
  output logic                          hit,
  output logic                          dirty,
  output logic [dcache_pkg::ADDR_W-1:0] mem_addr
);

  logic [dcache_pkg::TAG_W-1:0]   tag_mem [dcache_pkg::LINES];
  logic [dcache_pkg::LINES-1:0]   valid_bits;
  logic [dcache_pkg::LINES-1:0]   dirty_bits;
  logic [dcache_pkg::INDEX_W-1:0] index;
  logic [dcache_pkg::TAG_W-1:0]   req_tag;

  assign index   = req_addr[dcache_pkg::INDEX_W-1:0];
  assign req_tag = req_addr[dcache_pkg::ADDR_W-1:dcache_pkg::INDEX_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (replace_tag) begin
      valid_bits[index] <= set_valid;
      dirty_bits[index] <= set_dirty;
    end
  end

  always_ff @(posedge clk) begin
    if (replace_tag) begin
      tag_mem[index] <= req_tag;
    end
  end

  assign hit      = valid_bits[index] && (tag_mem[index] == req_tag);
  assign dirty    = valid_bits[index] && dirty_bits[index];
  assign mem_addr = tag_sel ? {tag_mem[index], index} : req_addr;  // Victim or request

  a_tag_valid: assert property (@(posedge clk) disable iff (rst) replace_tag |-> set_valid);

endmodule

// File: rtl/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            cpu_rden,
  input  logic                            cpu_wren,
  input  logic                            cpu_amoen,
  input  logic [dcache_pkg::ADDR_W-1:0]   cpu_addr,
  input  logic [dcache_pkg::DATA_W-1:0]   cpu_wdata,
  input  dcache_pkg::amo_op_e             cpu_amo_op,
  input  logic                            glob_stall,
  input  logic                            hit,
  input  logic                            dirty,
  input  logic                            mem_ready,
  output logic [dcache_pkg::ADDR_W-1:0]   req_addr,
  output logic [dcache_pkg::DATA_W-1:0]   req_wdata,
  output dcache_pkg::amo_op_e             req_op,
  output logic                            cache_wren,
  output dcache_pkg::insel_e              cache_insel,
  output logic                            mem_rden,
  output logic                            mem_wren,
  output logic                            set_dirty,
  output logic                            set_valid,
  output logic                            replace_tag,
  output logic                            tag_sel,
  output logic                            amo_buffer_en,
  output logic                            amo_unit_en,
  output logic                            dcache_stall
);

  dcache_pkg::state_e state, next_state;
  logic rden_reg, wren_reg, amoen_reg;
  logic new_req;
  logic accept;

  assign new_req = cpu_rden || cpu_wren || cpu_amoen;
  assign accept  = !glob_stall && !dcache_stall;  // Cache free to take a request

  always_ff @(posedge clk) begin
    if (rst) begin
      rden_reg  <= 1'b0;
      wren_reg  <= 1'b0;
      amoen_reg <= 1'b0;
    end else if (accept) begin
      rden_reg  <= cpu_rden;
      wren_reg  <= cpu_wren;
      amoen_reg <= cpu_amoen;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr  <= cpu_addr;
      req_wdata <= cpu_wdata;
      req_op    <= cpu_amo_op;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= dcache_pkg::IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state    = state;
    cache_wren    = 1'b0;
    cache_insel   = dcache_pkg::INSEL_CPU;
    mem_rden      = 1'b0;
    mem_wren      = 1'b0;
    set_dirty     = 1'b0;
    set_valid     = 1'b0;
    replace_tag   = 1'b0;
    tag_sel       = 1'b0;
    amo_buffer_en = 1'b0;
    amo_unit_en   = 1'b0;
    dcache_stall  = 1'b1;
    case (state)
      dcache_pkg::IDLE: begin
        dcache_stall = 1'b0;
        if (new_req && !glob_stall) begin
          next_state = dcache_pkg::COMPARE_TAG;
        end
      end
      dcache_pkg::COMPARE_TAG: begin
        if (hit && (rden_reg || wren_reg)) begin
          cache_wren   = wren_reg;   // CPU data on a write hit
          set_dirty    = 1'b1;
          set_valid    = 1'b1;
          replace_tag  = wren_reg;
          dcache_stall = 1'b0;
          if (glob_stall || new_req) begin
            next_state = dcache_pkg::COMPARE_TAG;
          end else begin
            next_state = dcache_pkg::IDLE;
          end
        end else if (hit && amoen_reg) begin
          set_dirty     = 1'b1;      // The AMO always stores
          set_valid     = 1'b1;
          replace_tag   = 1'b1;
          amo_buffer_en = 1'b1;      // Capture old value
          next_state    = dcache_pkg::AMO_MODIFY;
        end else if (dirty) begin
          mem_wren   = 1'b1;
          tag_sel    = 1'b1;         // Victim address
          set_dirty  = wren_reg;
          set_valid  = 1'b1;
          next_state = dcache_pkg::WRITE_BACK;
        end else begin
          mem_rden   = 1'b1;
          set_dirty  = wren_reg;
          set_valid  = 1'b1;
          next_state = dcache_pkg::ALLOCATE;
        end
      end
      dcache_pkg::WRITE_BACK: begin
        if (mem_ready) begin
          cache_insel = dcache_pkg::INSEL_MEM;
          mem_rden    = 1'b1;        // Refill starts right away
          next_state  = dcache_pkg::ALLOCATE;
        end else begin
          mem_wren  = 1'b1;
          tag_sel   = 1'b1;
          set_dirty = wren_reg;
          set_valid = 1'b1;
        end
      end
      dcache_pkg::ALLOCATE: begin
        if (mem_ready) begin
          cache_wren  = 1'b1;
          cache_insel = dcache_pkg::INSEL_MEM;
          set_dirty   = wren_reg || amoen_reg;
          set_valid   = 1'b1;
          replace_tag = 1'b1;
          next_state  = dcache_pkg::CACHE_ACCESS;
        end else begin
          mem_rden = 1'b1;
        end
      end
      dcache_pkg::CACHE_ACCESS: begin
        if (!amoen_reg) begin
          cache_wren   = wren_reg;
          dcache_stall = 1'b0;
          if (glob_stall) begin
            next_state = dcache_pkg::CACHE_ACCESS;
          end else if (new_req) begin
            next_state = dcache_pkg::COMPARE_TAG;
          end else begin
            next_state = dcache_pkg::IDLE;
          end
        end else begin
          amo_buffer_en = 1'b1;      // Refilled word is the old value
          next_state    = dcache_pkg::AMO_MODIFY;
        end
      end
      dcache_pkg::AMO_MODIFY: begin
        cache_insel   = dcache_pkg::INSEL_AMO;
        amo_buffer_en = 1'b1;
        amo_unit_en   = 1'b1;
        next_state    = dcache_pkg::AMO_STORE;
      end
      dcache_pkg::AMO_STORE: begin
        cache_wren   = 1'b1;
        cache_insel  = dcache_pkg::INSEL_AMO;
        amo_unit_en  = 1'b1;         // CPU sees the old value
        dcache_stall = 1'b0;
        if (glob_stall) begin
          next_state = dcache_pkg::AMO_STORE;
        end else if (new_req) begin
          next_state = dcache_pkg::COMPARE_TAG;
        end else begin
          next_state = dcache_pkg::IDLE;
        end
      end
      default: begin
        next_state = dcache_pkg::IDLE;
      end
    endcase
  end

  // One memory transfer direction at a time
  a_mem_excl: assert property (@(posedge clk) disable iff (rst) !(mem_rden && mem_wren));

  // IDLE is only held or entered once the access has completed
  a_idle_no_stall: assert property (@(posedge clk) disable iff (rst)
    (state == dcache_pkg::IDLE || next_state == dcache_pkg::IDLE) |-> !dcache_stall);

endmodule

// File: rtl/dcache_pkg.sv
package dcache_pkg;

  // Cache geometry, one word per line
  localparam int ADDR_W  = 10;  // Word address
  localparam int INDEX_W = 4;   // Line select, low address bits
  localparam int TAG_W   = ADDR_W - INDEX_W;
  localparam int LINES   = 1 << INDEX_W;
  localparam int DATA_W  = 32;

  // Controller states
  typedef enum logic [2:0] {
    IDLE         = 3'd0,
    COMPARE_TAG  = 3'd1,
    WRITE_BACK   = 3'd2,
    ALLOCATE     = 3'd3,
    CACHE_ACCESS = 3'd4,
    AMO_MODIFY   = 3'd5,
    AMO_STORE    = 3'd6
  } state_e;

  // Atomic memory operations
  typedef enum logic [2:0] {
    AMO_SWAP = 3'd0,
    AMO_ADD  = 3'd1,
    AMO_AND  = 3'd2,
    AMO_OR   = 3'd3,
    AMO_XOR  = 3'd4,
    AMO_MAX  = 3'd5   // Signed maximum
  } amo_op_e;

  // Write source of the data array
  typedef enum logic [1:0] {
    INSEL_CPU = 2'd0,
    INSEL_MEM = 2'd1,
    INSEL_AMO = 2'd2
  } insel_e;

endpackage
